// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // cache geometry
  localparam int addr_w = 32;
  localparam int ways = 4;
  localparam int sets = 16;
  localparam int words_per_block = 4;
  localparam int instr_w = 32;

  // derived field widths
  localparam int block_w = words_per_block * instr_w;
  localparam int byte_w = $clog2(instr_w / 8);
  localparam int word_w = $clog2(words_per_block);
  localparam int offset_w = byte_w + word_w;
  localparam int index_w = $clog2(sets);
  localparam int tag_w = addr_w - index_w - offset_w;
  localparam int way_w = $clog2(ways);

  typedef logic [addr_w-1:0] addr_t;

  // tag is everything above the set index
  typedef logic [tag_w-1:0] tag_t;

  typedef logic [index_w-1:0] index_t;
  typedef logic [word_w-1:0] word_sel_t;

  typedef logic [way_w-1:0] way_t;
  typedef logic [ways-1:0] way_vec_t;

  // one bit per inner node of the tree
  typedef logic [ways-2:0] lru_bits_t;

  typedef logic [instr_w-1:0] instr_t;

  // word 0 in the low bits
  typedef logic [block_w-1:0] block_t;

  typedef enum logic [1:0] {
    miss_idle,
    miss_request,
    miss_wait,
    miss_fill
  } miss_state_e;

endpackage

`default_nettype wire

// ==== icache_fill_if.sv ====
`default_nettype none

interface icache_fill_if;

  // single-cycle write strobe without a handshake
  logic                 fill_v;
  icache_pkg::index_t   index;
  icache_pkg::way_t     way;
  icache_pkg::tag_t     tag;
  icache_pkg::block_t   block;

  modport source (
    output fill_v,
    output index,
    output way,
    output tag,
    output block
  );

  modport sink (
    input fill_v,
    input index,
    input way,
    input tag,
    input block
  );

endinterface

`default_nettype wire

// ==== icache_tag_array.sv ====
`default_nettype none

module icache_tag_array (
  input  wire                                        clk_i,
  input  wire                                        reset_i,
  input  wire                                        rd_v_i,
  input  wire icache_pkg::index_t                    rd_index_i,
  icache_fill_if.sink                                fill,
  output icache_pkg::tag_t [icache_pkg::ways-1:0]    tags_o,
  output icache_pkg::way_vec_t                       valid_o
);

  icache_pkg::tag_t [icache_pkg::ways-1:0] tag_mem [icache_pkg::sets];
  icache_pkg::way_vec_t                    valid_q [icache_pkg::sets];

  // tag storage
  always_ff @(posedge clk_i) begin
    if (fill.fill_v) begin
      tag_mem[fill.index][fill.way] <= fill.tag;
    end
  end

  // valid bit per way and set
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < icache_pkg::sets; s++) begin
        valid_q[s] <= '0;
      end
    end else if (fill.fill_v) begin
      valid_q[fill.index][fill.way] <= 1'b1;
    end
  end

  // synchronous read of one set
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      tags_o <= tag_mem[rd_index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= '0;
    end else if (rd_v_i) begin
      valid_o <= valid_q[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// ==== icache_data_array.sv ====
`default_nettype none

module icache_data_array (
  input  wire                                         clk_i,
  input  wire                                         rd_v_i,
  input  wire icache_pkg::index_t                     rd_index_i,
  icache_fill_if.sink                                 fill,
  output icache_pkg::block_t [icache_pkg::ways-1:0]   blocks_o
);

  // one memory per way holding whole blocks
  for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
    icache_pkg::block_t block_mem [icache_pkg::sets];
    logic               wr_en;

    assign wr_en = fill.fill_v && (fill.way == icache_pkg::way_t'(w));

    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        block_mem[fill.index] <= fill.block;
      end
    end

    // all ways of the set are read together
    always_ff @(posedge clk_i) begin
      if (rd_v_i) begin
        blocks_o[w] <= block_mem[rd_index_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== icache_lru.sv ====
`default_nettype none

module icache_lru (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire                        hit_v_i,
  input  wire icache_pkg::index_t    hit_index_i,
  input  wire icache_pkg::way_t      hit_way_i,
  input  wire icache_pkg::way_vec_t  valid_i,
  icache_fill_if.sink                fill,
  output icache_pkg::way_t           victim_o
);

  icache_pkg::lru_bits_t lru_q [icache_pkg::sets];
  icache_pkg::lru_bits_t lru_cur;
  icache_pkg::way_t      lru_way;
  icache_pkg::way_t      invalid_way;
  logic                  invalid_found;
  logic                  upd_v;
  icache_pkg::index_t    upd_index;
  icache_pkg::way_t      upd_way;

  // point the tree away from the way just used
  function automatic icache_pkg::lru_bits_t touch(icache_pkg::lru_bits_t bits,
                                                  icache_pkg::way_t way);
    icache_pkg::lru_bits_t next;
    next = bits;
    next[0] = ~way[1];
    if (way[1]) begin
      next[2] = ~way[0];
    end else begin
      next[1] = ~way[0];
    end
    return next;
  endfunction

  // pipeline is stalled during a fill so fill and hit never coincide
  assign upd_v = fill.fill_v | hit_v_i;
  assign upd_index = fill.fill_v ? fill.index : hit_index_i;
  assign upd_way = fill.fill_v ? fill.way : hit_way_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < icache_pkg::sets; s++) begin
        lru_q[s] <= '0;
      end
    end else if (upd_v) begin
      lru_q[upd_index] <= touch(lru_q[upd_index], upd_way);
    end
  end

  // set bit means the upper half is older
  assign lru_cur = lru_q[hit_index_i];
  assign lru_way = {lru_cur[0], lru_cur[0] ? lru_cur[2] : lru_cur[1]};

  // lowest invalid way wins
  always_comb begin
    invalid_found = 1'b0;
    invalid_way = '0;
    for (int w = icache_pkg::ways - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        invalid_found = 1'b1;
        invalid_way = icache_pkg::way_t'(w);
      end
    end
  end

  assign victim_o = invalid_found ? invalid_way : lru_way;

endmodule

`default_nettype wire

// ==== icache_miss_unit.sv ====
`default_nettype none

module icache_miss_unit (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      miss_v_i,
  input  wire icache_pkg::addr_t   miss_addr_i,
  input  wire icache_pkg::way_t    victim_i,
  input  wire                      mem_req_ready_i,
  input  wire                      mem_resp_v_i,
  input  wire icache_pkg::block_t  mem_resp_data_i,
  output logic                     busy_o,
  output logic                     mem_req_v_o,
  output icache_pkg::addr_t        mem_req_addr_o,
  icache_fill_if.source            fill
);

  icache_pkg::miss_state_e state_q;
  icache_pkg::miss_state_e state_d;
  icache_pkg::addr_t       addr_q;
  icache_pkg::way_t        way_q;
  icache_pkg::block_t      block_q;
  logic                    capture;

  assign capture = (state_q == icache_pkg::miss_idle) && miss_v_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::miss_idle:    if (miss_v_i) state_d = icache_pkg::miss_request;
      icache_pkg::miss_request: if (mem_req_ready_i) state_d = icache_pkg::miss_wait;
      icache_pkg::miss_wait:    if (mem_resp_v_i) state_d = icache_pkg::miss_fill;
      default:                  state_d = icache_pkg::miss_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= icache_pkg::miss_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // block-aligned address and victim are taken at the miss
  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q <= {miss_addr_i[icache_pkg::addr_w-1:icache_pkg::offset_w],
                 {icache_pkg::offset_w{1'b0}}};
      way_q <= victim_i;
    end
    if ((state_q == icache_pkg::miss_wait) && mem_resp_v_i) begin
      block_q <= mem_resp_data_i;
    end
  end

  // busy from the miss cycle itself through the fill
  assign busy_o = miss_v_i | (state_q != icache_pkg::miss_idle);

  assign mem_req_v_o = (state_q == icache_pkg::miss_request);
  assign mem_req_addr_o = addr_q;

  assign fill.fill_v = (state_q == icache_pkg::miss_fill);
  assign fill.index = addr_q[icache_pkg::offset_w +: icache_pkg::index_w];
  assign fill.tag = addr_q[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
  assign fill.way = way_q;
  assign fill.block = block_q;

endmodule

`default_nettype wire

// ==== icache_pipeline.sv ====
`default_nettype none

module icache_pipeline (
  input  wire                                          clk_i,
  input  wire                                          reset_i,
  input  wire                                          fetch_v_i,
  input  wire icache_pkg::addr_t                       fetch_addr_i,
  input  wire icache_pkg::tag_t [icache_pkg::ways-1:0] tags_i,
  input  wire icache_pkg::way_vec_t                    valid_i,
  input  wire icache_pkg::block_t [icache_pkg::ways-1:0] blocks_i,
  input  wire                                          busy_i,
  output logic                                         fetch_ready_o,
  output logic                                         rd_v_o,
  output icache_pkg::index_t                           rd_index_o,
  output logic                                         data_v_o,
  output icache_pkg::instr_t                           data_o,
  output logic                                         miss_v_o,
  output icache_pkg::addr_t                            miss_addr_o,
  output logic                                         hit_v_o,
  output icache_pkg::index_t                           hit_index_o,
  output icache_pkg::way_t                             hit_way_o,
  output icache_pkg::way_vec_t                         tv_valid_o
);

  logic                 accept;
  logic                 tl_v_q;
  icache_pkg::addr_t    tl_addr_q;
  icache_pkg::tag_t     tl_tag;
  icache_pkg::way_vec_t hit_vec;
  logic                 tl_hit;
  icache_pkg::way_t     tl_way;
  logic                 tv_v_q;
  logic                 tv_hit_q;
  icache_pkg::way_t     tv_way_q;
  icache_pkg::addr_t    tv_addr_q;
  icache_pkg::block_t   tv_block_q;
  icache_pkg::way_vec_t tv_valid_q;
  icache_pkg::word_sel_t tv_word;

  assign fetch_ready_o = ~busy_i & ~miss_v_o;
  assign accept = fetch_v_i & fetch_ready_o;

  // arrays are read at the accepting edge
  assign rd_v_o = accept;
  assign rd_index_o = fetch_addr_i[icache_pkg::offset_w +: icache_pkg::index_w];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_q <= 1'b0;
    end else begin
      tl_v_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tl_addr_q <= fetch_addr_i;
    end
  end

  // tag compare
  assign tl_tag = tl_addr_q[icache_pkg::addr_w-1 -: icache_pkg::tag_w];

  always_comb begin
    tl_hit = 1'b0;
    tl_way = '0;
    for (int w = icache_pkg::ways - 1; w >= 0; w--) begin
      hit_vec[w] = valid_i[w] && (tags_i[w] == tl_tag);
      if (hit_vec[w]) begin
        tl_hit = 1'b1;
        tl_way = icache_pkg::way_t'(w);
      end
    end
  end

  // a miss leaving TV drops the fetch behind it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_q <= 1'b0;
    end else begin
      tv_v_q <= tl_v_q & ~miss_v_o;
    end
  end

  always_ff @(posedge clk_i) begin
    tv_hit_q <= tl_hit;
    tv_way_q <= tl_way;
    tv_addr_q <= tl_addr_q;
    tv_block_q <= blocks_i[tl_way];
    tv_valid_q <= valid_i;
  end

  assign tv_word = tv_addr_q[icache_pkg::byte_w +: icache_pkg::word_w];

  assign data_v_o = tv_v_q & tv_hit_q;
  assign data_o = tv_block_q[tv_word * icache_pkg::instr_w +: icache_pkg::instr_w];
  assign miss_v_o = tv_v_q & ~tv_hit_q;
  assign miss_addr_o = tv_addr_q;

  assign hit_v_o = data_v_o;
  assign hit_index_o = tv_addr_q[icache_pkg::offset_w +: icache_pkg::index_w];
  assign hit_way_o = tv_way_q;
  assign tv_valid_o = tv_valid_q;

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire                      fetch_v_i,
  input  wire icache_pkg::addr_t   fetch_addr_i,
  output logic                     fetch_ready_o,
  output logic                     data_v_o,
  output icache_pkg::instr_t       data_o,
  output logic                     miss_o,
  output logic                     mem_req_v_o,
  output icache_pkg::addr_t        mem_req_addr_o,
  input  wire                      mem_req_ready_i,
  input  wire                      mem_resp_v_i,
  input  wire icache_pkg::block_t  mem_resp_data_i
);

  logic                                    rd_v;
  icache_pkg::index_t                      rd_index;
  icache_pkg::tag_t [icache_pkg::ways-1:0] tags;
  icache_pkg::way_vec_t                    valid;
  icache_pkg::block_t [icache_pkg::ways-1:0] blocks;
  logic                                    miss_v;
  icache_pkg::addr_t                       miss_addr;
  logic                                    hit_v;
  icache_pkg::index_t                      hit_index;
  icache_pkg::way_t                        hit_way;
  icache_pkg::way_vec_t                    tv_valid;
  icache_pkg::way_t                        victim;
  logic                                    busy;

  icache_fill_if u_fill ();

  icache_pipeline u_pipeline (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_v_i     (fetch_v_i),
    .fetch_addr_i  (fetch_addr_i),
    .tags_i        (tags),
    .valid_i       (valid),
    .blocks_i      (blocks),
    .busy_i        (busy),
    .fetch_ready_o (fetch_ready_o),
    .rd_v_o        (rd_v),
    .rd_index_o    (rd_index),
    .data_v_o      (data_v_o),
    .data_o        (data_o),
    .miss_v_o      (miss_v),
    .miss_addr_o   (miss_addr),
    .hit_v_o       (hit_v),
    .hit_index_o   (hit_index),
    .hit_way_o     (hit_way),
    .tv_valid_o    (tv_valid)
  );

  icache_tag_array u_tag_array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_v_i     (rd_v),
    .rd_index_i (rd_index),
    .fill       (u_fill.sink),
    .tags_o     (tags),
    .valid_o    (valid)
  );

  icache_data_array u_data_array (
    .clk_i      (clk_i),
    .rd_v_i     (rd_v),
    .rd_index_i (rd_index),
    .fill       (u_fill.sink),
    .blocks_o   (blocks)
  );

  // victim is chosen from the set held in TV
  icache_lru u_lru (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .hit_v_i     (hit_v),
    .hit_index_i (hit_index),
    .hit_way_i   (hit_way),
    .valid_i     (tv_valid),
    .fill        (u_fill.sink),
    .victim_o    (victim)
  );

  icache_miss_unit u_miss_unit (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .miss_v_i        (miss_v),
    .miss_addr_i     (miss_addr),
    .victim_i        (victim),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i),
    .busy_o          (busy),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .fill            (u_fill.source)
  );

  assign miss_o = busy;

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== icache_props.sv ====
`default_nettype none

module icache_props (
  input wire        clk_i,
  input wire        reset_i,
  input wire        fetch_ready_i,
  input wire        data_v_i,
  input wire        miss_i,
  input wire        mem_req_v_i,
  input wire        mem_req_ready_i,
  input wire [31:0] mem_req_addr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // request held with a stable address until taken
  req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_i && !mem_req_ready_i |=> mem_req_v_i && $stable(mem_req_addr_i))
    else $error("memory request dropped or changed while not accepted");

  data_not_on_miss_start: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_i && $rose(miss_i)))
    else $error("data valid in the cycle a miss starts");

  ready_low_on_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_i |-> !fetch_ready_i)
    else $error("fetch ready high during a miss");

  req_idle_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !mem_req_v_i)
    else $error("memory request valid right after reset");

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache;

  timeunit 1ns;
  timeprecision 100ps;

  // 4 + 10 + 1 + 2 directed fetches plus 300 random ones
  localparam int unsigned num_fetches = 317;
  localparam int unsigned timeout_cycles = 40 * num_fetches;

  logic                  clk;
  logic                  reset;
  logic                  fetch_v;
  icache_pkg::addr_t     fetch_addr;
  logic                  fetch_ready;
  logic                  data_v;
  icache_pkg::instr_t    data;
  logic                  miss;
  logic                  mem_req_v;
  icache_pkg::addr_t     mem_req_addr;
  logic                  mem_req_ready;
  logic                  mem_resp_v;
  icache_pkg::block_t    mem_resp_data;

  // fetches waiting to be issued and accepted fetches awaiting a result
  icache_pkg::addr_t     issue_q [$];
  icache_pkg::addr_t     inflight [$];
  int unsigned           due_q [$];

  // addresses of the random stream
  icache_pkg::addr_t     rand_addr [300];

  // reference model state
  logic [23:0]           ref_tag [16][4];
  logic [3:0]            ref_valid [16];
  logic [2:0]            ref_tree [16];

  int unsigned           errors = 0;
  int unsigned           hits = 0;
  int unsigned           misses = 0;
  int unsigned           reqs = 0;
  int unsigned           discards = 0;
  int unsigned           cycles = 0;
  logic                  miss_prev = 1'b0;
  logic                  miss_rise_prev = 1'b0;
  logic                  req_pending = 1'b0;
  logic                  req_fire = 1'b0;
  logic                  stall_ready = 1'b0;
  icache_pkg::addr_t     miss_block = '0;
  icache_pkg::addr_t     resp_addr = '0;
  int unsigned           resp_wait = 0;

  tb_clock u_clock (
    .clk_o   (clk),
    .reset_o (reset)
  );

  icache_top u_dut (
    .clk_i           (clk),
    .reset_i         (reset),
    .fetch_v_i       (fetch_v),
    .fetch_addr_i    (fetch_addr),
    .fetch_ready_o   (fetch_ready),
    .data_v_o        (data_v),
    .data_o          (data),
    .miss_o          (miss),
    .mem_req_v_o     (mem_req_v),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_ready_i (mem_req_ready),
    .mem_resp_v_i    (mem_resp_v),
    .mem_resp_data_i (mem_resp_data)
  );

  bind icache_top icache_props u_props (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_ready_i   (fetch_ready_o),
    .data_v_i        (data_v_o),
    .miss_i          (miss_o),
    .mem_req_v_i     (mem_req_v_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_i  (mem_req_addr_o)
  );

  // memory word is a fixed scramble of its word address
  function automatic icache_pkg::instr_t mem_word(input icache_pkg::addr_t a);
    icache_pkg::addr_t w;
    w = {a[31:2], 2'b00};
    return (w * 32'h0019_660d) ^ 32'h3c6e_f35f ^ {w[15:0], w[31:16]};
  endfunction

  function automatic icache_pkg::block_t block_at(input icache_pkg::addr_t base);
    icache_pkg::block_t blk;
    for (int i = 0; i < 4; i++) begin
      blk[i*32 +: 32] = mem_word(base + icache_pkg::addr_t'(4 * i));
    end
    return blk;
  endfunction

  // tree bits {b2, b1, b0} where a set bit marks the upper half as older
  function automatic logic [2:0] tree_after_use(input logic [2:0] bits, input int way);
    case (way)
      0:       return {bits[2], 1'b1, 1'b1};
      1:       return {bits[2], 1'b0, 1'b1};
      2:       return {1'b1, bits[1], 1'b0};
      default: return {1'b0, bits[1], 1'b0};
    endcase
  endfunction

  function automatic int victim_of(input int set);
    int v;
    v = 0;
    while (v < 4 && ref_valid[set][v]) begin
      v++;
    end
    if (v < 4) begin
      return v;
    end
    if (ref_tree[set][0]) begin
      return ref_tree[set][2] ? 3 : 2;
    end
    return ref_tree[set][1] ? 1 : 0;
  endfunction

  // expected hit and word for a fetch and the install of a missed block
  function automatic logic ref_access(input icache_pkg::addr_t a,
                                      output icache_pkg::instr_t word);
    int set;
    int way;
    logic hit;
    set = int'(a[7:4]);
    way = -1;
    hit = 1'b0;
    for (int w = 0; w < 4; w++) begin
      if (ref_valid[set][w] && ref_tag[set][w] == a[31:8]) begin
        way = w;
      end
    end
    if (way < 0) begin
      way = victim_of(set);
      ref_valid[set][way] = 1'b1;
      ref_tag[set][way] = a[31:8];
    end else begin
      hit = 1'b1;
    end
    ref_tree[set] = tree_after_use(ref_tree[set], way);
    word = mem_word(a);
    return hit;
  endfunction

  task automatic report_mismatch(input string sig, input logic [127:0] exp_v,
                                 input logic [127:0] act_v);
    $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, sig, exp_v, act_v);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %0t ns %s", $time, what);
    errors++;
  endtask

  task automatic drain();
    do begin
      @(negedge clk);
    end while (issue_q.size() != 0 || inflight.size() != 0 || miss);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("run stopped at cycle %0d before the tests completed", cycles);
      $display("errors: %0d  hits: %0d  misses: %0d  requests: %0d",
               errors, hits, misses, reqs);
      $display("Something failed");
      $finish;
    end
  end

  // result and request checker on the falling edge
  always @(negedge clk) begin
    icache_pkg::addr_t  a;
    icache_pkg::instr_t exp_word;
    logic               exp_hit;
    logic               miss_rise;
    miss_rise = miss && !miss_prev;
    if (!reset) begin
      if (miss_rise_prev && !mem_req_v) begin
        report_failure("mem_req_v_o did not rise one cycle after the miss");
      end
      if (inflight.size() > 0 && due_q[0] == cycles) begin
        a = inflight.pop_front();
        void'(due_q.pop_front());
        exp_hit = ref_access(a, exp_word);
        if (data_v) begin
          hits++;
          if (!exp_hit) begin
            report_mismatch("miss_o", 1, 0);
          end else if (data != exp_word) begin
            report_mismatch("data_o", exp_word, data);
          end
        end else if (miss_rise) begin
          misses++;
          if (exp_hit) begin
            report_mismatch("miss_o", 0, 1);
          end
          miss_block = {a[31:4], 4'h0};
          req_pending = 1'b1;
          // replay the missed fetch and the one dropped behind it
          if (inflight.size() > 0) begin
            issue_q.push_front(inflight[0]);
            discards++;
          end
          issue_q.push_front(a);
          inflight.delete();
          due_q.delete();
        end else begin
          report_failure("no result two edges after an accepted fetch");
        end
      end else if (data_v || miss_rise) begin
        report_failure("result with no accepted fetch due");
      end
      if (mem_req_v && mem_req_ready) begin
        reqs++;
        if (!req_pending) begin
          report_failure("memory request with no miss outstanding");
        end else if (mem_req_addr != miss_block) begin
          report_mismatch("mem_req_addr_o", miss_block, mem_req_addr);
        end
        req_pending = 1'b0;
        req_fire = 1'b1;
        resp_addr = mem_req_addr;
      end
      if (fetch_v && fetch_ready) begin
        inflight.push_back(fetch_addr);
        due_q.push_back(cycles + 2);
        void'(issue_q.pop_front());
      end
    end
    miss_rise_prev = miss_rise && !reset;
    miss_prev = miss;
  end

  // fetch issue and memory responder driven 1 ns after the rising edge
  initial begin : drive_inputs
    fetch_v = 1'b0;
    fetch_addr = '0;
    mem_req_ready = 1'b0;
    mem_resp_v = 1'b0;
    mem_resp_data = '0;
    void'($urandom(1085));
    // random stream over a 1 KB window
    for (int n = 0; n < 300; n++) begin
      rand_addr[n] = 32'h0001_0000 + icache_pkg::addr_t'(($urandom % 256) << 2);
    end
    forever begin
      @(posedge clk);
      #1;
      fetch_v = (issue_q.size() > 0) && !reset;
      if (issue_q.size() > 0) begin
        fetch_addr = issue_q[0];
      end
      mem_resp_v = 1'b0;
      if (req_fire) begin
        resp_wait = 1 + $urandom % 6;
        req_fire = 1'b0;
      end else if (resp_wait > 0) begin
        resp_wait--;
        if (resp_wait == 0) begin
          mem_resp_v = 1'b1;
          mem_resp_data = block_at(resp_addr);
        end
      end
      mem_req_ready = !stall_ready && ($urandom % 3 != 0);
    end
  end

  initial begin : run_tests
    int unsigned base_miss;
    int unsigned base_hit;
    int unsigned base_req;
    int unsigned base_disc;
    icache_pkg::addr_t a0;
    for (int s = 0; s < 16; s++) begin
      ref_valid[s] = '0;
      ref_tree[s] = '0;
    end
    do begin
      @(negedge clk);
    end while (reset);
    if (!fetch_ready || data_v || miss || mem_req_v) begin
      report_failure("outputs not idle after reset");
    end

    // cold miss then hits on the whole block
    a0 = 32'h0000_1040;
    base_miss = misses;
    base_hit = hits;
    base_req = reqs;
    issue_q.push_back(a0 + 8);
    issue_q.push_back(a0);
    issue_q.push_back(a0 + 4);
    issue_q.push_back(a0 + 12);
    drain();
    if (misses - base_miss != 1) report_mismatch("miss count", 1, misses - base_miss);
    if (reqs - base_req != 1) report_mismatch("request count", 1, reqs - base_req);
    if (hits - base_hit != 4) report_mismatch("hit count", 4, hits - base_hit);

    // five blocks in set 0 where the extra hit on block 0 steers eviction to way 2
    base_miss = misses;
    for (int k = 0; k < 4; k++) begin
      issue_q.push_back(32'h0000_2000 + 32'h100 * k);
    end
    issue_q.push_back(32'h0000_2000);
    issue_q.push_back(32'h0000_2400);
    issue_q.push_back(32'h0000_2000);
    issue_q.push_back(32'h0000_2100);
    issue_q.push_back(32'h0000_2300);
    issue_q.push_back(32'h0000_2200);
    drain();
    if (misses - base_miss != 6) report_mismatch("miss count", 6, misses - base_miss);

    // memory holds off the request
    stall_ready = 1'b1;
    issue_q.push_back(32'h0000_3054);
    do begin
      @(negedge clk);
    end while (!mem_req_v);
    repeat (8) begin
      @(negedge clk);
      if (!mem_req_v) report_failure("mem_req_v_o dropped while not accepted");
      if (mem_req_addr != 32'h0000_3050) begin
        report_mismatch("mem_req_addr_o", 32'h0000_3050, mem_req_addr);
      end
      if (fetch_ready) report_failure("fetch_ready_o high during a stalled miss");
      if (data_v) report_failure("data_v_o high during a stalled miss");
    end
    stall_ready = 1'b0;
    drain();

    // a hit right behind a miss is dropped and replayed
    base_miss = misses;
    base_hit = hits;
    base_disc = discards;
    issue_q.push_back(32'h0000_3460);
    issue_q.push_back(a0 + 4);
    drain();
    if (discards - base_disc != 1) report_mismatch("discard count", 1, discards - base_disc);
    if (misses - base_miss != 1) report_mismatch("miss count", 1, misses - base_miss);
    if (hits - base_hit != 2) report_mismatch("hit count", 2, hits - base_hit);

    // random stream
    for (int n = 0; n < 300; n++) begin
      issue_q.push_back(rand_addr[n]);
    end
    drain();

    $display("errors: %0d  hits: %0d  misses: %0d  requests: %0d",
             errors, hits, misses, reqs);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
icache_pkg.sv
icache_fill_if.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_miss_unit.sv
icache_pipeline.sv
icache_top.sv
tb_clock.sv
icache_props.sv
tb_icache.sv

// ==== Makefile ====
TOP = tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f project.f \
		--top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
